//--- peak_buf_top.f
peak_buf_pkg.sv
peak_frame_writer.sv
peak_async_fifo.sv
ebi_read_port.sv
peak_buf_top.sv
tb_peak_buf.sv

//--- tb_peak_buf.sv
// testbench for the peak buffer: stimulus table, lane reference queue, compare tasks, watchdog
`timescale 1ns/1ps

module tb_peak_buf
  import peak_buf_pkg::*;
();

  localparam int NUM_ROWS    = 10;
  localparam int STALL_LIMIT = 20;

  logic       wr_clk;
  logic       rd_clk;
  logic       rst_n;
  logic       s_valid;
  peak_beat_t s_beat;
  logic       s_ready;
  logic       rd_ena;
  logic       rd_ready;
  ebi_word_t  rd_data;

  // stimulus table columns
  string               row_name  [NUM_ROWS];
  int                  row_beats [NUM_ROWS];
  logic [NUM_TAGS-1:0] row_tag   [NUM_ROWS];
  int                  row_gap   [NUM_ROWS];
  logic                row_hold  [NUM_ROWS];
  logic                table_loaded;

  // expected lanes and the row each came from
  ebi_word_t   exp_q [$];
  int          row_q [$];
  int          words_total;
  int          words_checked;
  logic [31:0] lfsr;
  logic        reads_held;
  logic        bp_seen;
  int          word_errors;
  int          flag_errors;

  peak_buf_top #(
    .FIFO_DEPTH (16)
  ) uut (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rst_n    (rst_n),
    .s_valid  (s_valid),
    .s_beat   (s_beat),
    .s_ready  (s_ready),
    .rd_ena   (rd_ena),
    .rd_ready (rd_ready),
    .rd_data  (rd_data)
  );

  // unrelated periods, 4 ns and 6 ns
  always #2 wr_clk = ~wr_clk;
  always #3 rd_clk = ~rd_clk;

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_word(input string name, input ebi_word_t exp, input ebi_word_t act);
    if (act !== exp) begin
      $display("error %s: expected %h actual %h", name, exp, act);
      word_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s: expected %b actual %b", name, exp, act);
      flag_errors++;
    end
  endtask

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
  endfunction

  // one step per bit taken
  task automatic rand_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_step(lfsr);
      w = {w[30:0], lfsr[0]};
    end
  endtask

  task automatic set_row(input int i, input string name, input int beats,
                         input logic [NUM_TAGS-1:0] tag, input int gap, input logic hold);
    row_name[i]  = name;
    row_beats[i] = beats;
    row_tag[i]   = tag;
    row_gap[i]   = gap;
    row_hold[i]  = hold;
  endtask

  task automatic load_table();
    set_row(0, "single_beat", 1, 10'h2a5, 0, 1'b0);
    set_row(1, "multi_a",     3, 10'h101, 0, 1'b0);
    set_row(2, "multi_b",     4, 10'h102, 0, 1'b0);
    set_row(3, "multi_c",     2, 10'h103, 0, 1'b0);
    // held reads, pushes well past the fifo depth
    set_row(4, "bp_0",        4, 10'h1f0, 0, 1'b1);
    set_row(5, "bp_1",        4, 10'h1f1, 0, 1'b1);
    set_row(6, "bp_2",        4, 10'h1f2, 0, 1'b1);
    set_row(7, "bp_3",        4, 10'h1f3, 0, 1'b1);
    // idle cycles carry last with a wrong tag
    set_row(8, "gap_last",    3, 10'h3c7, 2, 1'b0);
    set_row(9, "gap_single",  1, 10'h055, 3, 1'b0);
  endtask

  // lanes of one entry, lowest first
  task automatic push_entry(input fifo_entry_t entry, input int row);
    for (int l = 0; l < LANES_PER_ENTRY; l++) begin
      exp_q.push_back(entry[l*EBI_WIDTH +: EBI_WIDTH]);
      row_q.push_back(row);
    end
  endtask

  // present a beat and hold it until accepted
  task automatic drive_beat(input peak_beat_t beat);
    int stall;
    stall = 0;
    s_valid <= 1'b1;
    s_beat  <= beat;
    @(negedge wr_clk);
    while (!s_ready) begin
      stall++;
      // long stall under held reads is real back-pressure
      if (stall >= STALL_LIMIT && reads_held) begin
        bp_seen    = 1'b1;
        reads_held = 1'b0;
      end
      @(negedge wr_clk);
    end
    @(posedge wr_clk);
  endtask

  task automatic idle_cycle(input logic [NUM_TAGS-1:0] tag);
    peak_beat_t fake;
    fake.data = '1;
    fake.tag  = ~tag;
    fake.last = 1'b1;
    s_valid <= 1'b0;
    s_beat  <= fake;
    @(posedge wr_clk);
  endtask

  task automatic run_row(input int r);
    peak_beat_t  beat;
    fifo_entry_t tag_entry;
    logic [31:0] w;
    reads_held = row_hold[r];
    for (int b = 0; b < row_beats[r]; b++) begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        rand_word(w);
        beat.data[c*CHANNEL_WIDTH +: CHANNEL_WIDTH] = w;
      end
      beat.last = (b == row_beats[r] - 1);
      // inner beats carry a decoy tag
      beat.tag  = beat.last ? row_tag[r] : ~row_tag[r];
      push_entry(beat.data, r);
      if (beat.last) begin
        tag_entry = '0;
        tag_entry[NUM_TAGS-1:0] = row_tag[r];
        push_entry(tag_entry, r);
      end
      drive_beat(beat);
      if (beat.last) begin
        @(negedge wr_clk);
        check_flag({row_name[r], " s_ready after last"}, 1'b0, s_ready);
        @(posedge wr_clk);
      end
      repeat (row_gap[r]) idle_cycle(row_tag[r]);
    end
  endtask

  // one strobe pulse, returns where rd_data is settled
  task automatic pulse_read();
    @(posedge rd_clk);
    rd_ena <= 1'b1;
    @(posedge rd_clk);
    rd_ena <= 1'b0;
    @(negedge rd_clk);
  endtask

  //////////////////////////////
  // processes
  //////////////////////////////

  initial begin : reader
    ebi_word_t exp_word;
    int        r;
    forever begin
      @(negedge rd_clk);
      if (rd_ready === 1'b1 && !reads_held && exp_q.size() > 0) begin
        pulse_read();
        exp_word = exp_q.pop_front();
        r = row_q.pop_front();
        check_word(row_name[r], exp_word, rd_data);
        words_checked++;
      end
    end
  end

  initial begin : watchdog
    int beats;
    int limit_ns;
    wait (table_loaded === 1'b1);
    beats = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      beats += row_beats[r];
    end
    limit_ns = (beats + NUM_ROWS) * LANES_PER_ENTRY * 40 + 2000;
    #(limit_ns);
    $display("watchdog expired before all words were read");
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    ebi_word_t last_word;
    wr_clk        = 1'b0;
    rd_clk        = 1'b0;
    rst_n         = 1'b0;
    s_valid       = 1'b0;
    s_beat        = '0;
    rd_ena        = 1'b0;
    lfsr          = 32'ha59f_8e11;
    reads_held    = 1'b0;
    bp_seen       = 1'b0;
    word_errors   = 0;
    flag_errors   = 0;
    words_checked = 0;
    load_table();
    // data entries plus one tag entry per frame
    words_total = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      words_total += (row_beats[r] + 1) * LANES_PER_ENTRY;
    end
    table_loaded = 1'b1;
    repeat (3) @(posedge wr_clk);
    rst_n <= 1'b1;

    // idle state and a read with nothing buffered
    @(negedge wr_clk);
    check_flag("reset s_ready", 1'b1, s_ready);
    check_flag("reset rd_ready", 1'b0, rd_ready);
    pulse_read();
    check_word("idle read", '0, rd_data);

    @(posedge wr_clk);
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    reads_held = 1'b0;
    s_valid <= 1'b0;

    while (words_checked < words_total) begin
      @(posedge rd_clk);
    end
    repeat (4) @(posedge rd_clk);
    @(negedge rd_clk);
    check_flag("final rd_ready", 1'b0, rd_ready);
    last_word = rd_data;
    pulse_read();
    check_word("final idle read", last_word, rd_data);
    check_flag("back-pressure stall", 1'b1, bp_seen);

    $display("errors: word %0d, flag %0d", word_errors, flag_errors);
    if (word_errors == 0 && flag_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- peak_buf_top.sv
// peak buffer top, frame writer to async fifo to bus read port
`timescale 1ns/1ps

module peak_buf_top
  import peak_buf_pkg::*;
#(
  parameter int FIFO_DEPTH  = 16,
  parameter int SYNC_STAGES = 3
) (
  input  logic       wr_clk,
  input  logic       rd_clk,
  input  logic       rst_n,
  input  logic       s_valid,
  input  peak_beat_t s_beat,
  output logic       s_ready,
  input  logic       rd_ena,
  output logic       rd_ready,
  output ebi_word_t  rd_data
);

  // write side link
  logic        wr_en;
  fifo_entry_t wr_entry;
  logic        full;

  // read side link
  logic        rd_en;
  fifo_entry_t rd_entry;
  logic        empty;

  peak_frame_writer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_writer (
    .wr_clk   (wr_clk),
    .rst_n    (rst_n),
    .s_valid  (s_valid),
    .s_beat   (s_beat),
    .s_ready  (s_ready),
    .wr_en    (wr_en),
    .wr_entry (wr_entry),
    .full     (full)
  );

  peak_async_fifo #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_fifo (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_entry (wr_entry),
    .full     (full),
    .rd_en    (rd_en),
    .rd_entry (rd_entry),
    .empty    (empty)
  );

  ebi_read_port u_read_port (
    .rd_clk   (rd_clk),
    .rst_n    (rst_n),
    .rd_ena   (rd_ena),
    .rd_ready (rd_ready),
    .rd_data  (rd_data),
    .rd_en    (rd_en),
    .rd_entry (rd_entry),
    .empty    (empty)
  );

endmodule

//--- ebi_read_port.sv
// read strobe edge detect, entry prefetch and 16-bit lane serializer
`timescale 1ns/1ps

module ebi_read_port
  import peak_buf_pkg::*;
(
  input  logic        rd_clk,
  input  logic        rst_n,
  input  logic        rd_ena,
  output logic        rd_ready,
  output ebi_word_t   rd_data,
  output logic        rd_en,
  input  fifo_entry_t rd_entry,
  input  logic        empty
);

  // strobe from the previous edge
  logic rd_ena_d;
  logic read_edge;

  // set for the cycle after a fifo read
  logic fetch_pending;

  // prefetched entry and the next lane to hand out
  fifo_entry_t               lane_buf;
  logic                      buf_valid;
  logic [LANE_IDX_WIDTH-1:0] lane_idx;

  assign read_edge = rd_ena & ~rd_ena_d;

  // one fetch at a time and only into an empty buffer
  assign rd_en = ~buf_valid & ~fetch_pending & ~empty;

  assign rd_ready = buf_valid;

  //////////////////////////////
  // strobe and fetch control
  //////////////////////////////

  always_ff @(posedge rd_clk) begin
    if (!rst_n) begin
      rd_ena_d      <= 1'b0;
      fetch_pending <= 1'b0;
    end else begin
      rd_ena_d      <= rd_ena;
      fetch_pending <= rd_en;
    end
  end

  //////////////////////////////
  // lane buffer
  //////////////////////////////

  always_ff @(posedge rd_clk) begin
    if (!rst_n) begin
      buf_valid <= 1'b0;
      lane_idx  <= '0;
      rd_data   <= '0;
    end else if (fetch_pending) begin
      buf_valid <= 1'b1;
      lane_idx  <= '0;
    end else if (read_edge && buf_valid) begin
      rd_data  <= lane_buf[lane_idx*EBI_WIDTH +: EBI_WIDTH];
      lane_idx <= lane_idx + 1'b1;
      // last lane drained so the next entry gets fetched
      if (lane_idx == LANE_IDX_WIDTH'(LANES_PER_ENTRY - 1)) begin
        buf_valid <= 1'b0;
      end
    end
  end

  // entry payload from the fifo
  always_ff @(posedge rd_clk) begin
    if (fetch_pending) begin
      lane_buf <= rd_entry;
    end
  end

  // no fetch over unread lanes
  a_no_fetch_busy : assert property (@(posedge rd_clk) disable iff (!rst_n)
    rd_en |-> !buf_valid);

endmodule

//--- peak_async_fifo.sv
// dual-clock fifo of wide entries, gray pointers and synchronizer chains
`timescale 1ns/1ps

module peak_async_fifo
  import peak_buf_pkg::*;
#(
  parameter int FIFO_DEPTH  = 16,
  parameter int SYNC_STAGES = 3
) (
  input  logic        wr_clk,
  input  logic        rd_clk,
  input  logic        rst_n,
  input  logic        wr_en,
  input  fifo_entry_t wr_entry,
  output logic        full,
  input  logic        rd_en,
  output fifo_entry_t rd_entry,
  output logic        empty
);

  // address bits, pointers carry one extra wrap bit
  localparam int AW = $clog2(FIFO_DEPTH);
  localparam int PW = AW + 1;

  // entry storage
  fifo_entry_t mem [FIFO_DEPTH];

  // write domain pointers
  logic [PW-1:0] wr_bin;
  logic [PW-1:0] wr_gray;
  logic [PW-1:0] wr_bin_next;

  // read domain pointers
  logic [PW-1:0] rd_bin;
  logic [PW-1:0] rd_gray;
  logic [PW-1:0] rd_bin_next;

  // cross-domain copies, last stage is the usable one
  logic [PW-1:0] rd_gray_sync [SYNC_STAGES];
  logic [PW-1:0] wr_gray_sync [SYNC_STAGES];

  logic wr_fire;
  logic rd_fire;

  //////////////////////////////
  // write side
  //////////////////////////////

  assign wr_fire     = wr_en & ~full;
  assign wr_bin_next = wr_bin + PW'(wr_fire);

  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_next;
      wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_fire) begin
      mem[wr_bin[AW-1:0]] <= wr_entry;
    end
  end

  // read pointer into the write clock
  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        rd_gray_sync[i] <= '0;
      end
    end else begin
      rd_gray_sync[0] <= rd_gray;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        rd_gray_sync[i] <= rd_gray_sync[i-1];
      end
    end
  end

  // full when read side is one lap behind, top two gray bits flipped
  assign full = (wr_gray == {~rd_gray_sync[SYNC_STAGES-1][PW-1:PW-2],
                             rd_gray_sync[SYNC_STAGES-1][PW-3:0]});

  //////////////////////////////
  // read side
  //////////////////////////////

  assign rd_fire     = rd_en & ~empty;
  assign rd_bin_next = rd_bin + PW'(rd_fire);

  always_ff @(posedge rd_clk) begin
    if (!rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_next;
      rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
    end
  end

  // registered output, valid the cycle after the pop
  always_ff @(posedge rd_clk) begin
    if (rd_fire) begin
      rd_entry <= mem[rd_bin[AW-1:0]];
    end
  end

  // write pointer into the read clock
  always_ff @(posedge rd_clk) begin
    if (!rst_n) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        wr_gray_sync[i] <= '0;
      end
    end else begin
      wr_gray_sync[0] <= wr_gray;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        wr_gray_sync[i] <= wr_gray_sync[i-1];
      end
    end
  end

  assign empty = (rd_gray == wr_gray_sync[SYNC_STAGES-1]);

  // upstream must respect full
  a_no_overflow : assert property (@(posedge wr_clk) disable iff (!rst_n)
    wr_en |-> !full);

  // downstream must respect empty
  a_no_underflow : assert property (@(posedge rd_clk) disable iff (!rst_n)
    rd_en |-> !empty);

endmodule

//--- peak_frame_writer.sv
// write-side frame control, beat acceptance and trailing tag entry insertion
`timescale 1ns/1ps

module peak_frame_writer
  import peak_buf_pkg::*;
#(
  parameter int FIFO_DEPTH = 16
) (
  input  logic        wr_clk,
  input  logic        rst_n,
  input  logic        s_valid,
  input  peak_beat_t  s_beat,
  output logic        s_ready,
  output logic        wr_en,
  output fifo_entry_t wr_entry,
  input  logic        full
);

  // depth must be a power of two and at least 4
  if (FIFO_DEPTH < 4 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : g_depth_check
    $error("FIFO_DEPTH must be a power of two, 4 or more");
  end

  // tag entry waiting to go into the fifo
  logic                tag_pending;
  // tag from the last accepted last beat
  logic [NUM_TAGS-1:0] tag_q;

  logic beat_acc;
  logic tag_wr;

  // hold the stream off while the tag entry is owed
  assign s_ready  = ~tag_pending & ~full;
  assign beat_acc = s_valid & s_ready;

  // tag goes in on the first non-full cycle after the frame
  assign tag_wr = tag_pending & ~full;

  assign wr_en    = beat_acc | tag_wr;
  assign wr_entry = tag_pending ? {{PAD_WIDTH{1'b0}}, tag_q} : s_beat.data;

  //////////////////////////////
  // pending tag control
  //////////////////////////////

  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      tag_pending <= 1'b0;
    end else if (tag_wr) begin
      tag_pending <= 1'b0;
    end else if (beat_acc && s_beat.last) begin
      tag_pending <= 1'b1;
    end
  end

  // only an accepted last beat updates the tag
  always_ff @(posedge wr_clk) begin
    if (beat_acc && s_beat.last) begin
      tag_q <= s_beat.tag;
    end
  end

  // never push into a full fifo
  a_no_wr_full : assert property (@(posedge wr_clk) disable iff (!rst_n)
    full |-> !wr_en);

endmodule

//--- peak_buf_pkg.sv
// peak buffer constants, beat struct, fifo entry and bus word types
package peak_buf_pkg;

  //////////////////////////////
  // detector and bus sizes
  //////////////////////////////

  // detector channels carried in one beat
  localparam int NUM_CHANNELS = 4;
  localparam int CHANNEL_WIDTH = 32;

  // one beat and one fifo entry share this width
  localparam int DATA_WIDTH = NUM_CHANNELS * CHANNEL_WIDTH;

  // tag field width
  localparam int NUM_TAGS = 10;

  // zero fill above the tag in a tag entry
  localparam int PAD_WIDTH = DATA_WIDTH - NUM_TAGS;

  // external microcontroller bus
  localparam int EBI_WIDTH = 16;
  localparam int LANES_PER_ENTRY = DATA_WIDTH / EBI_WIDTH;
  localparam int LANE_IDX_WIDTH = $clog2(LANES_PER_ENTRY);

  //////////////////////////////
  // shared types
  //////////////////////////////

  // one stream beat, last at the top, data at the bottom
  typedef struct packed {
    logic                  last;
    logic [NUM_TAGS-1:0]   tag;
    logic [DATA_WIDTH-1:0] data;
  } peak_beat_t;

  // fifo entry, beat data or zero-padded tag
  typedef logic [DATA_WIDTH-1:0] fifo_entry_t;

  // one lane as seen on the bus
  typedef logic [EBI_WIDTH-1:0] ebi_word_t;

endpackage
